//--- rtl/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// ---------------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------------
`define LCD_NIBBLE_WIDTH 4      // 4-bit interface, DB7..DB4
`define LCD_BYTE_WIDTH 8        // command or character

// ---------------------------------------------------------------------------
// enable pulse shape, in clock cycles
// ---------------------------------------------------------------------------
`define LCD_SETUP_CYCLES 2      // data and rs stable before enable rises
`define LCD_ENABLE_CYCLES 12    // enable high time
`define LCD_HOLD_CYCLES 1       // data held after enable falls

// pause between upper and lower nibble of one byte
`define LCD_NIBBLE_GAP_US 1

// ---------------------------------------------------------------------------
// controller waits, in microseconds
// ---------------------------------------------------------------------------
`define LCD_WAIT_15MS_US 15000  // power-on settle
`define LCD_WAIT_4100_US 4100   // after first 0x3
`define LCD_WAIT_100_US 100     // after second 0x3
`define LCD_WAIT_40_US 40       // most commands and data
`define LCD_WAIT_1640_US 1640   // clear display

`define LCD_WAIT_COUNT_WIDTH 32 // enough for 15 ms at any sane clock

// transfers the nibble writer takes at once
`define LCD_CREDITS 1

`endif

//--- rtl/lcd_timing_pkg.sv
`default_nettype none
`include "lcd_consts.svh"

package lcd_timing_pkg;

   // which wait follows a sequencer step
   typedef enum logic [2:0]
   {
      wait15ms,       // power-on
      wait4100us,     // after first init nibble
      wait100us,      // after second init nibble
      wait40us,       // default command/data wait
      wait1640us      // clear display
   } waitSel_t;

   // cycle counter for waits and pulse phases
   typedef logic [`LCD_WAIT_COUNT_WIDTH-1:0] waitCount_t;

endpackage

`default_nettype wire

//--- rtl/lcd_bus_pkg.sv
`default_nettype none
`include "lcd_consts.svh"

package lcd_bus_pkg;

   // writer's view of a byte
   typedef struct packed
   {
      logic [`LCD_NIBBLE_WIDTH-1:0] upper;   // sent first
      logic [`LCD_NIBBLE_WIDTH-1:0] lower;   // sent second, or alone in init
   } lcdNibbles_t;

   // sequencer sees a whole code, writer sees two nibbles
   typedef union packed
   {
      logic [`LCD_BYTE_WIDTH-1:0] whole;     // command code or character
      lcdNibbles_t                nibbles;
   } lcdByte_t;

   // one transfer from sequencer to writer
   typedef struct packed
   {
      lcdByte_t value;
      logic     registerSelect;              // 0 command, 1 data
      logic     nibbleOnly;                  // lower nibble only, power-on init
   } lcdTransfer_t;

   // pins toward the display
   typedef struct packed
   {
      logic                         enable;
      logic                         registerSelect;
      logic                         readWrite;       // write only
      logic                         strataFlashOff;  // keeps flash off the shared bus
      logic [`LCD_NIBBLE_WIDTH-1:0] data;
   } lcdPins_t;

endpackage

`default_nettype wire

//--- rtl/lcdDelayTimer.sv
`timescale 1ns/10ps
`default_nettype none
`include "lcd_consts.svh"

module lcdDelayTimer #(
   parameter int ClockMhz = 50                      // cycles per microsecond
) (
   input  logic                     Clock,
   input  logic                     arstN,
   input  logic                     waitStart,
   input  lcd_timing_pkg::waitSel_t waitSel,
   output logic                     waitDone
);

   lcd_timing_pkg::waitCount_t waitUs;              // selected wait in us
   lcd_timing_pkg::waitCount_t waitCount;           // cycles left
   logic                       running;

   // microseconds for each wait
   always_comb
   begin
      case (waitSel)
         lcd_timing_pkg::wait15ms:   waitUs = `LCD_WAIT_15MS_US;
         lcd_timing_pkg::wait4100us: waitUs = `LCD_WAIT_4100_US;
         lcd_timing_pkg::wait100us:  waitUs = `LCD_WAIT_100_US;
         lcd_timing_pkg::wait1640us: waitUs = `LCD_WAIT_1640_US;
         default:                    waitUs = `LCD_WAIT_40_US;
      endcase
   end

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         running   <= 1'b0;
         waitCount <= '0;
      end
      else if (waitStart)
      begin
         running   <= 1'b1;
         waitCount <= waitUs * ClockMhz - 1;        // zero lands on cycle N
      end
      else if (running)
      begin
         if (waitCount == '0)
            running <= 1'b0;                        // done shown this cycle
         else
            waitCount <= waitCount - 1'b1;
      end
   end

   assign waitDone = running && (waitCount == '0);  // one-cycle pulse

   // sequencer only restarts after it has seen the previous done
   assert property (@(posedge Clock) disable iff (!arstN) waitStart |-> !running);

endmodule

`default_nettype wire

//--- rtl/lcdNibbleWriter.sv
`timescale 1ns/10ps
`default_nettype none
`include "lcd_consts.svh"

module lcdNibbleWriter #(
   parameter int ClockMhz = 50                          // cycles per microsecond
) (
   input  logic                      Clock,
   input  logic                      arstN,
   input  lcd_bus_pkg::lcdTransfer_t transfer,
   input  logic                      transferValid,
   output logic                      creditReturn,
   output lcd_bus_pkg::lcdPins_t     lcd
);

   // each phase runs until its counter load counts down to zero
   localparam lcd_timing_pkg::waitCount_t SetupLoad  = `LCD_SETUP_CYCLES - 1;
   localparam lcd_timing_pkg::waitCount_t EnableLoad = `LCD_ENABLE_CYCLES - 1;
   localparam lcd_timing_pkg::waitCount_t HoldLoad   = `LCD_HOLD_CYCLES - 1;
   localparam lcd_timing_pkg::waitCount_t GapLoad    = `LCD_NIBBLE_GAP_US * ClockMhz - 1;

   typedef enum logic [2:0]
   {
      phIdle,
      phSetup,        // data out, enable low
      phEnable,       // enable high
      phHold,         // enable low, data kept
      phGap           // pause before lower nibble
   } phase_t;

   phase_t                       phase;
   lcd_timing_pkg::waitCount_t   phaseCount;
   logic                         countDone;
   logic                         secondPending;         // lower nibble still to go
   logic                         selectReg;
   logic [`LCD_NIBBLE_WIDTH-1:0] dataNibble;            // nibble on the pins
   logic [`LCD_NIBBLE_WIDTH-1:0] lowerNibble;           // parked second half

   assign countDone = (phaseCount == '0);

   // ------------------------------------------------------------------------
   // phase machine
   // ------------------------------------------------------------------------
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         phase         <= phIdle;
         phaseCount    <= '0;
         secondPending <= 1'b0;
         selectReg     <= 1'b0;
         dataNibble    <= '0;
      end
      else
      begin
         if (phase != phIdle && !countDone)
            phaseCount <= phaseCount - 1'b1;            // phase changes reload below
         case (phase)
            phIdle:
               if (transferValid)
               begin
                  phase         <= phSetup;
                  phaseCount    <= SetupLoad;
                  selectReg     <= transfer.registerSelect;
                  secondPending <= !transfer.nibbleOnly;
                  dataNibble    <= transfer.nibbleOnly ? transfer.value.nibbles.lower
                                                       : transfer.value.nibbles.upper;
               end
            phSetup:
               if (countDone)
               begin
                  phase      <= phEnable;
                  phaseCount <= EnableLoad;
               end
            phEnable:
               if (countDone)
               begin
                  phase      <= phHold;
                  phaseCount <= HoldLoad;
               end
            phHold:
               if (countDone)
               begin
                  phase      <= secondPending ? phGap : phIdle;
                  phaseCount <= GapLoad;                // only used by the gap
               end
            phGap:
               if (countDone)
               begin
                  phase         <= phSetup;
                  phaseCount    <= SetupLoad;
                  secondPending <= 1'b0;
                  dataNibble    <= lowerNibble;         // same shape again
               end
            default:
               phase <= phIdle;
         endcase
      end
   end

   // second half of a byte
   always_ff @(posedge Clock)
   begin
      if (phase == phIdle && transferValid)
         lowerNibble <= transfer.value.nibbles.lower;
   end

   // last hold cycle of the last nibble
   assign creditReturn = (phase == phHold) && countDone && !secondPending;

   assign lcd = '{
      enable:         (phase == phEnable),
      registerSelect: selectReg,
      readWrite:      1'b0,                             // never read back
      strataFlashOff: 1'b1,
      data:           dataNibble
   };

   // display latches on the falling edge, so the bus must not move under enable
   assert property (@(posedge Clock) disable iff (!arstN)
      lcd.enable |=> !lcd.enable || ($stable(lcd.data) && $stable(lcd.registerSelect)));

   // sequencer holds no credit while a transfer is in flight
   assert property (@(posedge Clock) disable iff (!arstN)
      transferValid |-> phase == phIdle);

endmodule

`default_nettype wire

//--- rtl/lcdStartupSequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "lcd_consts.svh"

module lcdStartupSequencer (
   input  logic                      Clock,
   input  logic                      arstN,
   output lcd_bus_pkg::lcdTransfer_t transfer,
   output logic                      transferValid,
   input  logic                      creditReturn,
   output logic                      waitStart,
   output lcd_timing_pkg::waitSel_t  waitSel,
   input  logic                      waitDone,
   output logic                      done
);

   localparam int StepWidth   = 5;
   localparam int LastStep    = 19;                     // leading wait + 19 transfers
   localparam int CreditWidth = $clog2(`LCD_CREDITS + 1) + 1;  // spare bit shows overflow
   localparam logic [10*`LCD_BYTE_WIDTH-1:0] Phrase = "Hola Mundo";

   typedef struct packed
   {
      lcd_bus_pkg::lcdTransfer_t transfer;
      lcd_timing_pkg::waitSel_t  waitSel;               // wait after the transfer
   } stepEntry_t;

   typedef enum logic [2:0]
   {
      stIssue,        // send the step's transfer
      stCredit,       // writer busy
      stStartWait,    // kick the delay timer
      stWaiting,
      stDone
   } state_t;

   state_t                 state;
   logic [StepWidth-1:0]   step;
   logic [CreditWidth-1:0] credits;
   stepEntry_t             romEntry;

   function automatic stepEntry_t makeStep(
      input logic [`LCD_BYTE_WIDTH-1:0] code,
      input logic                       select,
      input logic                       nibbleOnly,
      input lcd_timing_pkg::waitSel_t   sel
   );
      stepEntry_t entry;
      entry.transfer.value.whole     = code;
      entry.transfer.registerSelect  = select;
      entry.transfer.nibbleOnly      = nibbleOnly;
      entry.waitSel                  = sel;
      return entry;
   endfunction

   // ------------------------------------------------------------------------
   // step ROM of power-on init then configuration then phrase
   // ------------------------------------------------------------------------
   always_comb
   begin
      case (step)
         5'd0:    romEntry = makeStep(8'h00, 1'b0, 1'b1, lcd_timing_pkg::wait15ms);
         5'd1:    romEntry = makeStep(8'h03, 1'b0, 1'b1, lcd_timing_pkg::wait4100us);
         5'd2:    romEntry = makeStep(8'h03, 1'b0, 1'b1, lcd_timing_pkg::wait100us);
         5'd3:    romEntry = makeStep(8'h03, 1'b0, 1'b1, lcd_timing_pkg::wait40us);
         5'd4:    romEntry = makeStep(8'h02, 1'b0, 1'b1, lcd_timing_pkg::wait40us);
         5'd5:    romEntry = makeStep(8'h28, 1'b0, 1'b0, lcd_timing_pkg::wait40us);
         5'd6:    romEntry = makeStep(8'h06, 1'b0, 1'b0, lcd_timing_pkg::wait40us);
         5'd7:    romEntry = makeStep(8'h0C, 1'b0, 1'b0, lcd_timing_pkg::wait40us);
         5'd8:    romEntry = makeStep(8'h01, 1'b0, 1'b0, lcd_timing_pkg::wait1640us);
         5'd9:    romEntry = makeStep(8'h80, 1'b0, 1'b0, lcd_timing_pkg::wait40us);
         default: romEntry = makeStep(Phrase[`LCD_BYTE_WIDTH * (LastStep - step) +: 8],
                                      1'b1, 1'b0, lcd_timing_pkg::wait40us);
      endcase
   end

   assign transfer = romEntry.transfer;
   assign waitSel  = romEntry.waitSel;

   // ------------------------------------------------------------------------
   // step walker
   // ------------------------------------------------------------------------
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         state <= stIssue;
         step  <= '0;
      end
      else
      begin
         case (state)
            stIssue:
               if (step == '0)
                  state <= stStartWait;                 // leading wait, nothing to send
               else if (transferValid)
                  state <= stCredit;
            stCredit:
               if (creditReturn)
                  state <= stStartWait;
            stStartWait:
               state <= stWaiting;
            stWaiting:
               if (waitDone)
               begin
                  if (step == StepWidth'(LastStep))
                     state <= stDone;                   // parked until reset
                  else
                  begin
                     state <= stIssue;
                     step  <= step + 1'b1;
                  end
               end
            default:
               state <= stDone;
         endcase
      end
   end

   // spent on send, back on writer's return
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         credits <= CreditWidth'(`LCD_CREDITS);
      else
         credits <= credits - CreditWidth'(transferValid) + CreditWidth'(creditReturn);
   end

   assign transferValid = (state == stIssue) && (step != '0) && (credits != '0);
   assign waitStart     = (state == stStartWait);
   assign done          = (state == stDone);

   // once the last credit goes out, nothing else is sent until the writer returns it
   assert property (@(posedge Clock) disable iff (!arstN)
      (transferValid && credits == CreditWidth'(1)) |=> !transferValid until creditReturn);

   // writer never returns more than it was given
   assert property (@(posedge Clock) disable iff (!arstN)
      credits <= CreditWidth'(`LCD_CREDITS));

endmodule

`default_nettype wire

//--- rtl/lcdHelloTop.sv
`timescale 1ns/10ps
`default_nettype none

module lcdHelloTop #(
   parameter int ClockMhz = 50                  // board clock in MHz
) (
   input  logic                  Clock,
   input  logic                  arstN,
   output lcd_bus_pkg::lcdPins_t lcd,
   output logic                  done
);

   lcd_bus_pkg::lcdTransfer_t transfer;         // sequencer to writer
   logic                      transferValid;
   logic                      creditReturn;
   lcd_timing_pkg::waitSel_t  waitSel;          // sequencer to timer
   logic                      waitStart;
   logic                      waitDone;

   // init, configuration and phrase steps
   lcdStartupSequencer sequencer (
      .Clock         (Clock),
      .arstN         (arstN),
      .transfer      (transfer),
      .transferValid (transferValid),
      .creditReturn  (creditReturn),
      .waitStart     (waitStart),
      .waitSel       (waitSel),
      .waitDone      (waitDone),
      .done          (done)
   );

   // controller waits between steps
   lcdDelayTimer #(
      .ClockMhz (ClockMhz)
   ) delayTimer (
      .Clock     (Clock),
      .arstN     (arstN),
      .waitStart (waitStart),
      .waitSel   (waitSel),
      .waitDone  (waitDone)
   );

   // nibbles and enable pulses on the pins
   lcdNibbleWriter #(
      .ClockMhz (ClockMhz)
   ) nibbleWriter (
      .Clock         (Clock),
      .arstN         (arstN),
      .transfer      (transfer),
      .transferValid (transferValid),
      .creditReturn  (creditReturn),
      .lcd           (lcd)
   );

endmodule

`default_nettype wire

//--- verif/lcdHelloTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "lcd_consts.svh"

module lcdHelloTb;

   localparam int ClockMhz       = 1;               // 1 cycle per us keeps waits short
   localparam int ClockPeriod    = 10;              // ns
   localparam int DriveDelay     = 1;               // ns after rising edge
   localparam int ResetCycles    = 10;
   localparam int PostDoneCycles = 300;             // quiet time after done

   // one line of the data file
   typedef struct packed
   {
      logic                       isReset;
      logic                       registerSelect;
      logic [`LCD_BYTE_WIDTH-1:0] value;
      logic                       nibbleOnly;
      int                         count;            // min gap in us or transfers before reset
   } testRecord_t;

   // one enable pulse seen on the pins
   typedef struct packed
   {
      int                           riseCyc;
      int                           fallCyc;
      logic                         registerSelect;
      logic [`LCD_NIBBLE_WIDTH-1:0] data;
   } nibblePulse_t;

   logic                  Clock;
   logic                  arstN;
   lcd_bus_pkg::lcdPins_t lcd;
   logic                  done;

   testRecord_t           tests[$];
   nibblePulse_t          nibbles[$];               // captured and not yet checked
   nibblePulse_t          pulse;                    // pulse in progress
   lcd_bus_pkg::lcdPins_t prevPins;
   int                    cyc = 0;                  // negedge count
   int                    sinceChange = 0;          // cycles rs/data unchanged
   int                    holdLeft = 0;
   int                    lastFall = 0;             // end of previous transfer
   int                    errors = 0;
   int                    transfersChecked = 0;
   int                    timeoutCycles = 0;
   logic                  testsLoaded = 1'b0;

   lcdHelloTop #(
      .ClockMhz (ClockMhz)
   ) uut (
      .Clock (Clock),
      .arstN (arstN),
      .lcd   (lcd),
      .done  (done)
   );

   initial
   begin
      Clock = 1'b0;
      forever #(ClockPeriod / 2) Clock = ~Clock;
   end

   task automatic logError(input string msg);
      errors++;
      $display("error @ %0t: %s", $time, msg);
   endtask

   // ------------------------------------------------------------------------
   // data file and watchdog
   // ------------------------------------------------------------------------
   task automatic loadTests();
      int          fd;
      int          status;
      string       line;
      byte         kind;
      int          rs;
      int          value;
      int          nibOnly;
      int          count;
      testRecord_t rec;
      fd = $fopen("verif/lcd_tests.txt", "r");
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line = "";
            status = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#")
               continue;                            // blank or column notes
            status = $sscanf(line, "%c %h %h %h %d", kind, rs, value, nibOnly, count);
            rec.isReset        = (kind == "R");
            rec.registerSelect = rs[0];
            rec.value          = value[`LCD_BYTE_WIDTH-1:0];
            rec.nibbleOnly     = nibOnly[0];
            rec.count          = count;
            tests.push_back(rec);
            if (!rec.isReset)
               timeoutCycles += count * ClockMhz;   // waits dominate the run
         end
         $fclose(fd);
         timeoutCycles += tests.size() * 64 + PostDoneCycles + 1000;  // pulses, resets, slack
         testsLoaded = 1'b1;
      end
   endtask

   initial
   begin
      wait (testsLoaded);
      #(longint'(timeoutCycles) * ClockPeriod);
      $display("watchdog expired after %0d cycles, the sequence never finished", timeoutCycles);
      $display("sim failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // pin monitor sampled on the falling clock edge
   // ------------------------------------------------------------------------
   always @(negedge Clock)
   begin
      cyc++;
      if (!arstN)
      begin
         prevPins    = '0;
         sinceChange = 0;
         holdLeft    = 0;
      end
      else
      begin
         assert (lcd.readWrite == 1'b0 && lcd.strataFlashOff == 1'b1)
            else logError("readWrite or strataFlashOff left its fixed level");
         if ({lcd.registerSelect, lcd.data} != {prevPins.registerSelect, prevPins.data})
            sinceChange = 0;
         else
            sinceChange++;
         if (lcd.enable && !prevPins.enable)       // rise
         begin
            assert (sinceChange >= `LCD_SETUP_CYCLES)
               else logError($sformatf("setup only %0d cycles before enable", sinceChange));
            assert (!done) else logError("enable pulse while done is high");
            pulse.riseCyc        = cyc;
            pulse.registerSelect = lcd.registerSelect;
            pulse.data           = lcd.data;
         end
         if (lcd.enable && prevPins.enable)
            assert (lcd.data == pulse.data && lcd.registerSelect == pulse.registerSelect)
               else logError("data or rs moved while enable high");
         if (!lcd.enable && prevPins.enable)       // fall where the display latches
         begin
            pulse.fallCyc = cyc;
            assert (cyc - pulse.riseCyc == `LCD_ENABLE_CYCLES)
               else logError($sformatf("enable high %0d cycles", cyc - pulse.riseCyc));
            holdLeft = `LCD_HOLD_CYCLES;
            nibbles.push_back(pulse);
         end
         if (holdLeft > 0)
         begin
            assert (lcd.data == pulse.data && lcd.registerSelect == pulse.registerSelect)
               else logError("data or rs moved during hold");
            holdLeft--;
         end
         prevPins = lcd;
      end
   end

   // ------------------------------------------------------------------------
   // stimulus and transfer checks
   // ------------------------------------------------------------------------
   task automatic applyReset();
      @(posedge Clock);
      #(DriveDelay) arstN = 1'b0;
      repeat (ResetCycles) @(posedge Clock);
      #(DriveDelay) arstN = 1'b1;
      nibbles.delete();
      lastFall = cyc;                               // first gap counts from release
      @(negedge Clock);
      assert (!lcd.enable && !done && !lcd.readWrite && lcd.strataFlashOff)
         else logError("pins not at reset levels after reset");
   endtask

   task automatic takeNibble(output nibblePulse_t n);
      while (nibbles.size() == 0)
         @(negedge Clock);
      n = nibbles.pop_front();
   endtask

   task automatic checkTransfer(input testRecord_t rec);
      nibblePulse_t               first;
      nibblePulse_t               last;
      logic [`LCD_BYTE_WIDTH-1:0] got;
      takeNibble(first);
      last = first;
      got  = {4'h0, first.data};                    // init nibble alone
      assert (first.riseCyc - lastFall >= rec.count * ClockMhz)
         else logError($sformatf("gap %0d cycles, need %0d", first.riseCyc - lastFall,
                                 rec.count * ClockMhz));
      if (!rec.nibbleOnly)
      begin
         takeNibble(last);
         got = {first.data, last.data};             // upper then lower
         assert (last.riseCyc - first.fallCyc >=
                 `LCD_HOLD_CYCLES + `LCD_NIBBLE_GAP_US * ClockMhz + `LCD_SETUP_CYCLES)
            else logError("nibbles of one byte too close");
         assert (last.registerSelect == first.registerSelect)
            else logError("rs differs between nibbles");
      end
      assert (first.registerSelect == rec.registerSelect && got == rec.value)
         else logError($sformatf("got rs %0b value %02h, expected rs %0b value %02h",
                                 first.registerSelect, got, rec.registerSelect, rec.value));
      lastFall = last.fallCyc;
      transfersChecked++;
   endtask

   initial
   begin
      int sinceReset;
      arstN      = 1'b0;
      sinceReset = 0;
      loadTests();
      if (!testsLoaded)
      begin
         $display("could not open the test data file verif/lcd_tests.txt");
         $display("sim failed");
         $finish;
      end
      else
      begin
         applyReset();
         foreach (tests[i])
         begin
            if (tests[i].isReset)
            begin
               assert (sinceReset == tests[i].count)
                  else logError($sformatf("reset record after %0d transfers, file says %0d",
                                          sinceReset, tests[i].count));
               applyReset();                        // sequence starts over
               sinceReset = 0;
            end
            else
            begin
               checkTransfer(tests[i]);
               sinceReset++;
            end
         end
         while (done !== 1'b1)
            @(negedge Clock);
         assert (cyc - lastFall >= `LCD_WAIT_40_US * ClockMhz)
            else logError("done rose before the last character's wait");
         assert (nibbles.size() == 0) else logError("extra transfers before done");
         repeat (PostDoneCycles) @(negedge Clock);
         assert (nibbles.size() == 0 && done && !lcd.enable)
            else logError("activity on the bus after done");
         $display("transfers checked %0d, errors %0d", transfersChecked, errors);
         if (errors == 0)
            $display("sim passed");
         else
            $display("sim failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verif/lcd_tests.txt
# kind rs value(hex) nibbleOnly count
# T transfer, count = min gap in us since last enable fall; R reset after count transfers
T 0 03 1 15000
T 0 03 1 4100
T 0 03 1 100
T 0 02 1 40
T 0 28 0 40
T 0 06 0 40
T 0 0C 0 40
R 0 00 0 7
T 0 03 1 15000
T 0 03 1 4100
T 0 03 1 100
T 0 02 1 40
T 0 28 0 40
T 0 06 0 40
T 0 0C 0 40
T 0 01 0 40
T 0 80 0 1640
T 1 48 0 40
T 1 6F 0 40
T 1 6C 0 40
T 1 61 0 40
T 1 20 0 40
T 1 4D 0 40
T 1 75 0 40
T 1 6E 0 40
T 1 64 0 40
T 1 6F 0 40

//--- all.f
+incdir+rtl
rtl/lcd_timing_pkg.sv
rtl/lcd_bus_pkg.sv
rtl/lcdDelayTimer.sv
rtl/lcdNibbleWriter.sv
rtl/lcdStartupSequencer.sv
rtl/lcdHelloTop.sv
verif/lcdHelloTb.sv

//--- Bender.yml
package:
  name: lcd_hello

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lcd_timing_pkg.sv
      - rtl/lcd_bus_pkg.sv
      - rtl/lcdDelayTimer.sv
      - rtl/lcdNibbleWriter.sv
      - rtl/lcdStartupSequencer.sv
      - rtl/lcdHelloTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/lcdHelloTb.sv
